// ==== vsaPkg.sv ====
/*
 * shared widths, encodings and word types for the VSA subsystem
 * opcodes 6 and 7 are unused and run as no-ops
 * immediates are zero-extended; the ISA never sign-extends them
 * both memories are memDepth words deep, addressed by addressType
 */
package vsaPkg;

    localparam int dataWidth  = 5;   // registers and data bus
    localparam int instrWidth = 12;  // one instruction word
    localparam int addrWidth  = 5;   // pc and data address
    localparam int memDepth   = 32;  // words per memory

    typedef logic [dataWidth-1:0]  dataType;
    typedef logic [instrWidth-1:0] instructionType;
    typedef logic [addrWidth-1:0]  addressType;

    // five phases of the non-pipelined unit
    typedef enum logic [2:0] {
        fetch     = 3'd0,
        decode    = 3'd1,
        execute   = 3'd2,
        memory    = 3'd3,
        writeBack = 3'd4
    } phaseType;

    // instruction bits 11:9
    typedef enum logic [2:0] {
        opLw   = 3'd0,
        opSw   = 3'd1,
        opBeqz = 3'd2,
        opAlu  = 3'd3,  // R-format, see function field
        opAddi = 3'd4,
        opSubi = 3'd5
    } opcodeType;

    // R-format function, instruction bits 2:0
    typedef enum logic [2:0] {
        fnAdd = 3'd0,
        fnSub = 3'd1,
        fnAnd = 3'd2,
        fnOr  = 3'd3,
        fnXor = 3'd4,
        fnNot = 3'd5,  // A only
        fnSrl = 3'd6,  // A only, zero fill
        fnSra = 3'd7   // A only, keeps msb
    } aluFunctionType;

endpackage

// ==== vsaControl.sv ====
/*
 * phase sequencer and instruction-class decoder
 * every instruction takes five cycles, fetch through writeBack
 * opcode must come from IR, so it is stale during fetch;
 * no fetch-phase strobe depends on it
 */
`timescale 1ns/1ps

module vsaControl (
    input  logic              clock,
    input  logic              reset,
    input  vsaPkg::opcodeType opcode,
    output vsaPkg::phaseType  phase,
    output logic              loadIr,
    output logic              loadOperands,
    output logic              loadResult,
    output logic              updatePc,
    output logic              loadLmd,
    output logic              memWrite,
    output logic              regWrite,
    output logic              isMemRef,
    output logic              isRegReg,
    output logic              isRegImm,
    output logic              isBranch
);

    // phase counter 0..4, wraps
    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= vsaPkg::fetch;
        end else if (phase == vsaPkg::writeBack) begin
            phase <= vsaPkg::fetch;
        end else begin
            phase <= vsaPkg::phaseType'(phase + 3'd1);
        end
    end

    // instruction classes
    assign isMemRef = (opcode == vsaPkg::opLw) || (opcode == vsaPkg::opSw);
    assign isRegReg = (opcode == vsaPkg::opAlu);
    assign isRegImm = (opcode == vsaPkg::opAddi) || (opcode == vsaPkg::opSubi);
    assign isBranch = (opcode == vsaPkg::opBeqz);  // codes 6,7 fall in no class

    // one strobe per phase
    assign loadIr       = (phase == vsaPkg::fetch);    // IR, NPC
    assign loadOperands = (phase == vsaPkg::decode);   // A, B
    assign loadResult   = (phase == vsaPkg::execute);  // ALUOutput, Cond
    assign updatePc     = (phase == vsaPkg::memory);
    assign loadLmd      = (phase == vsaPkg::memory) && (opcode == vsaPkg::opLw);
    assign memWrite     = (phase == vsaPkg::memory) && (opcode == vsaPkg::opSw);

    // write-back only for instructions with a destination
    assign regWrite = (phase == vsaPkg::writeBack)
                    && (isRegReg || isRegImm || (opcode == vsaPkg::opLw));

endmodule

// ==== vsaRegFile.sv ====
/*
 * four-entry register file, R0 reads as zero
 * two combinational read ports, one synchronous write port
 * writes to index 0 are dropped here
 */
`timescale 1ns/1ps

module vsaRegFile (
    input  logic            clock,
    input  logic            reset,
    input  logic [1:0]      readSelect1,
    input  logic [1:0]      readSelect2,
    input  logic [1:0]      writeSelect,
    input  logic            writeEnable,
    input  vsaPkg::dataType writeData,
    output vsaPkg::dataType readData1,
    output vsaPkg::dataType readData2
);

    vsaPkg::dataType registers [1:3];  // R1..R3 only, no R0 storage

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 4; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && (writeSelect != 2'd0)) begin
            registers[writeSelect] <= writeData;
        end
    end

    assign readData1 = (readSelect1 == 2'd0) ? '0 : registers[readSelect1];  // R0 = 0
    assign readData2 = (readSelect2 == 2'd0) ? '0 : registers[readSelect2];

endmodule

// ==== vsaAlu.sv ====
/*
 * combinational execute unit
 * results wrap modulo 32; unused opcodes give zero
 * immediate arrives zero-extended
 * branch target is nextPc plus twice the low four immediate bits
 */
`timescale 1ns/1ps

module vsaAlu (
    input  vsaPkg::dataType        operandA,
    input  vsaPkg::dataType        operandB,
    input  vsaPkg::dataType        immediate,
    input  vsaPkg::addressType     nextPc,
    input  vsaPkg::opcodeType      opcode,
    input  vsaPkg::aluFunctionType functionCode,  // function field
    input  logic                   isMemRef,
    input  logic                   isRegReg,
    input  logic                   isRegImm,
    input  logic                   isBranch,
    output vsaPkg::dataType        aluResult,
    output logic                   isZero
);

    always_comb begin
        aluResult = '0;  // no-op opcodes
        if (isMemRef) begin
            aluResult = operandA + immediate;  // effective address
        end else if (isRegReg) begin
            case (functionCode)
                vsaPkg::fnAdd: aluResult = operandA + operandB;
                vsaPkg::fnSub: aluResult = operandA - operandB;
                vsaPkg::fnAnd: aluResult = operandA & operandB;
                vsaPkg::fnOr:  aluResult = operandA | operandB;
                vsaPkg::fnXor: aluResult = operandA ^ operandB;
                vsaPkg::fnNot: aluResult = ~operandA;
                vsaPkg::fnSrl: aluResult = {1'b0, operandA[4:1]};
                vsaPkg::fnSra: aluResult = {operandA[4], operandA[4:1]};
                default:       aluResult = '0;
            endcase
        end else if (isRegImm) begin
            if (opcode == vsaPkg::opSubi) begin
                aluResult = operandA - immediate;
            end else begin
                aluResult = operandA + immediate;  // ADDI
            end
        end else if (isBranch) begin
            aluResult = nextPc + {immediate[3:0], 1'b0};  // target, even
        end
    end

    // BEQZ condition, latched as Cond by the core
    assign isZero = (operandA == '0);

endmodule

// ==== vsaMemory.sv ====
/*
 * 32-word memory, word type set per instance
 * combinational read, write on the clock edge
 * with clearOnReset low the array ignores reset and accepts
 * writes while reset is high (program load)
 */
`timescale 1ns/1ps

module vsaMemory #(
    parameter type wordType = vsaPkg::dataType
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               clearOnReset,  // strap, tied per instance
    input  logic               writeEnable,
    input  vsaPkg::addressType writeAddress,
    input  vsaPkg::addressType readAddress,
    input  wordType            writeData,
    output wordType            readData
);

    wordType storage [vsaPkg::memDepth];

    always_ff @(posedge clock) begin
        if (reset && clearOnReset) begin
            for (int i = 0; i < vsaPkg::memDepth; i++) begin
                storage[i] <= '0;  // data memory starts clean
            end
        end else if (writeEnable) begin
            storage[writeAddress] <= writeData;
        end
    end

    assign readData = storage[readAddress];  // same-cycle answer

endmodule

// ==== vsaCore.sv ====
/*
 * five-phase, non-pipelined VSA core
 * pc steps by two; BEQZ resolves in the memory phase
 * dataAddress is ALUOutput and dataOut is B, held between strobes
 * expects combinational instruction and data reads
 */
`timescale 1ns/1ps

module vsaCore (
    input  logic                   clock,
    input  logic                   reset,
    input  vsaPkg::instructionType instruction,
    input  vsaPkg::dataType        dataIn,
    output vsaPkg::addressType     pc,
    output vsaPkg::addressType     dataAddress,
    output vsaPkg::dataType        dataOut,
    output logic                   memWrite
);

    // datapath registers
    vsaPkg::addressType     npc;
    vsaPkg::instructionType ir;
    vsaPkg::dataType        a;
    vsaPkg::dataType        b;
    vsaPkg::dataType        aluOutput;
    logic                   cond;
    vsaPkg::dataType        lmd;

    // IR fields
    vsaPkg::opcodeType      opcode;
    vsaPkg::aluFunctionType functionCode;
    vsaPkg::dataType        immediate;
    logic [1:0]             source1;
    logic [1:0]             source2;  // also I-format destination
    logic [1:0]             destination;

    // control and datapath wires
    vsaPkg::phaseType phase;
    logic             loadIr, loadOperands, loadResult, updatePc, loadLmd, regWrite;
    logic             isMemRef, isRegReg, isRegImm, isBranch, isZero;
    vsaPkg::dataType  readData1, readData2, aluResult, writeData;
    logic [1:0]       writeSelect;

    assign opcode       = vsaPkg::opcodeType'(ir[11:9]);
    assign source1      = ir[8:7];
    assign source2      = ir[6:5];
    assign destination  = ir[4:3];
    assign functionCode = vsaPkg::aluFunctionType'(ir[2:0]);
    assign immediate    = ir[4:0];  // zero-extended, 5 bits already

    vsaControl control_inst (
        .clock, .reset, .opcode, .phase, .loadIr, .loadOperands, .loadResult,
        .updatePc, .loadLmd, .memWrite, .regWrite, .isMemRef, .isRegReg,
        .isRegImm, .isBranch
    );

    // write-back mux: LMD for LW, ALUOutput otherwise
    assign writeData   = (opcode == vsaPkg::opLw) ? lmd : aluOutput;
    assign writeSelect = isRegReg ? destination : source2;

    vsaRegFile regFile_inst (
        .clock, .reset, .readSelect1(source1), .readSelect2(source2),
        .writeSelect, .writeEnable(regWrite), .writeData, .readData1, .readData2
    );

    vsaAlu alu_inst (
        .operandA(a), .operandB(b), .immediate, .nextPc(npc), .opcode, .functionCode,
        .isMemRef, .isRegReg, .isRegImm, .isBranch, .aluResult, .isZero
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            pc        <= '0;
            npc       <= '0;
            ir        <= '0;
            a         <= '0;
            b         <= '0;
            aluOutput <= '0;
            cond      <= 1'b0;
            lmd       <= '0;
        end else begin
            if (loadIr) begin  // end of fetch
                ir  <= instruction;
                npc <= pc + vsaPkg::addressType'(2);
            end
            if (loadOperands) begin  // end of decode
                a <= readData1;
                b <= readData2;
            end
            if (loadResult) begin  // end of execute
                aluOutput <= aluResult;
                cond      <= isZero;  // only meaningful for BEQZ
            end
            if (updatePc) begin
                pc <= (isBranch && cond) ? aluOutput : npc;  // taken branch or next
            end
            if (loadLmd) begin
                lmd <= dataIn;  // LW read data
            end
        end
    end

    assign dataAddress = aluOutput;
    assign dataOut     = b;

endmodule

// ==== vsaSystem.sv ====
/*
 * VSA subsystem top: core plus program and data memories
 * load the program through programWrite/Address/Data while reset
 * is high; program memory keeps its contents across reset
 * data memory is cleared by reset
 */
`timescale 1ns/1ps

module vsaSystem (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   programWrite,
    input  vsaPkg::addressType     programAddress,
    input  vsaPkg::instructionType programData,
    output vsaPkg::addressType     pc,
    output vsaPkg::addressType     dataAddress,
    output vsaPkg::dataType        dataOut,
    output logic                   memWrite
);

    vsaPkg::instructionType instruction;  // program memory read data
    vsaPkg::dataType        dataIn;       // data memory read data

    vsaCore core_inst (
        .clock, .reset, .instruction, .dataIn, .pc, .dataAddress, .dataOut, .memWrite
    );

    // program memory, written only from the top-level ports
    vsaMemory #(.wordType(vsaPkg::instructionType)) instructionMemory (
        .clock, .reset,
        .clearOnReset(1'b0),
        .writeEnable(programWrite),
        .writeAddress(programAddress),
        .readAddress(pc),
        .writeData(programData),
        .readData(instruction)
    );

    // data memory, one address for load and store
    vsaMemory #(.wordType(vsaPkg::dataType)) dataMemory (
        .clock, .reset,
        .clearOnReset(1'b1),
        .writeEnable(memWrite),
        .writeAddress(dataAddress),
        .readAddress(dataAddress),
        .writeData(dataOut),
        .readData(dataIn)
    );

endmodule

// ==== vsaCoreProperties.sv ====
/*
 * internal checks on vsaCore, attached with bind
 * all properties are off while reset is high
 * failureCount is read by the testbench for its summary
 */
`timescale 1ns/1ps

module vsaCoreProperties (
    input logic               clock,
    input logic               reset,
    input vsaPkg::phaseType   phase,
    input vsaPkg::addressType pc,
    input vsaPkg::dataType    a,
    input logic               cond,
    input logic               isBranch
);

    int failureCount = 0;

    // Cond holds the zero test of A until the branch resolves
    condMatchesA: assert property (@(posedge clock) disable iff (reset)
        isBranch && (phase == vsaPkg::memory || phase == vsaPkg::writeBack)
        |-> cond == (a == 5'd0))
        else begin
            failureCount++;
            $error("Cond differs from the zero test of A during a branch");
        end

    phaseSteps: assert property (@(posedge clock) disable iff (reset)
        phase != vsaPkg::writeBack |=> phase == $past(phase) + 3'd1)
        else begin
            failureCount++;
            $error("phase did not advance by one");
        end

    phaseWraps: assert property (@(posedge clock) disable iff (reset)
        phase == vsaPkg::writeBack |=> phase == vsaPkg::fetch)
        else begin
            failureCount++;
            $error("phase did not wrap from writeBack to fetch");
        end

    pcEven: assert property (@(posedge clock) disable iff (reset) pc[0] == 1'b0)
        else begin
            failureCount++;
            $error("pc is odd");
        end

endmodule

bind vsaCore vsaCoreProperties coreProperties_inst (
    .clock(clock), .reset(reset), .phase(phase), .pc(pc), .a(a), .cond(cond),
    .isBranch(isBranch)
);

// ==== vsaSystemTb.sv ====
/*
 * random-program testbench for vsaSystem against an ISA reference model
 * program load runs while reset is high; odd program words are zero
 * model steps one instruction per 5 cycles from the first fetch
 * outputs are sampled on the falling edge and inputs driven on the rising edge
 */
`timescale 1ns/1ps

module vsaSystemTb;

    localparam int clockPeriod    = 20;
    localparam int runLength      = 60;                 // instructions
    localparam int watchdogCycles = runLength * 5 + 20;

    logic                   clock;
    logic                   reset;
    logic                   programWrite;
    vsaPkg::addressType     programAddress;
    vsaPkg::instructionType programData;
    vsaPkg::addressType     pc;
    vsaPkg::addressType     dataAddress;
    vsaPkg::dataType        dataOut;
    logic                   memWrite;

    vsaPkg::instructionType programImage [0:31];
    vsaPkg::dataType        modelRegs [0:3];  // R0 stays zero
    vsaPkg::dataType        modelMem [0:31];
    vsaPkg::addressType     modelPc;
    logic                   expectStore;
    vsaPkg::addressType     expectAddress;
    vsaPkg::dataType        expectData;
    integer                 seed;
    int                     cycleCount = 0;
    int                     retired = 0;
    int                     slot;
    int                     checkCount = 0;
    int                     errorCount = 0;

    vsaSystem vsaSystem_inst (
        .clock, .reset, .programWrite, .programAddress, .programData,
        .pc, .dataAddress, .dataOut, .memWrite
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    task automatic compareSignal(input string name, input logic [11:0] expected,
                                 input logic [11:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("ERROR at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    function automatic vsaPkg::dataType modelAlu(input logic [2:0] fn,
                                                 input vsaPkg::dataType x,
                                                 input vsaPkg::dataType y);
        case (fn)
            3'd0: return x + y;            // wraps mod 32
            3'd1: return x - y;
            3'd2: return x & y;
            3'd3: return x | y;
            3'd4: return x ^ y;
            3'd5: return ~x;
            3'd6: return x >> 1;           // zero fill
            default: return {x[4], x[4:1]};  // arithmetic shift
        endcase
    endfunction

    task automatic writeRegister(input logic [1:0] index, input vsaPkg::dataType value);
        if (index != 2'd0) begin
            modelRegs[index] = value;
        end
    endtask

    // one instruction of the reference ISA and its store expectation
    task automatic stepModel();
        vsaPkg::instructionType word;
        logic [2:0]             op;
        vsaPkg::dataType        valueA;
        vsaPkg::dataType        valueB;
        vsaPkg::dataType        imm;
        vsaPkg::addressType     address;
        vsaPkg::addressType     nextPc;
        word    = programImage[modelPc];
        op      = word[11:9];
        valueA  = modelRegs[word[8:7]];
        valueB  = modelRegs[word[6:5]];
        imm     = word[4:0];  // no sign extension
        address = valueA + imm;
        nextPc  = modelPc + 5'd2;
        expectStore = (op == vsaPkg::opSw);
        case (op)
            vsaPkg::opLw:   writeRegister(word[6:5], modelMem[address]);
            vsaPkg::opSw: begin
                expectAddress     = address;
                expectData        = valueB;
                modelMem[address] = valueB;
            end
            vsaPkg::opBeqz: if (valueA == 5'd0) nextPc = nextPc + {imm[3:0], 1'b0};
            vsaPkg::opAlu:  writeRegister(word[4:3], modelAlu(word[2:0], valueA, valueB));
            vsaPkg::opAddi: writeRegister(word[6:5], valueA + imm);
            vsaPkg::opSubi: writeRegister(word[6:5], valueA - imm);
            default: ;  // codes 6, 7 do nothing
        endcase
        modelPc = nextPc;
    endtask

    // sampled on the falling edge; slot 0 is the fetch cycle
    always @(negedge clock) begin
        if (reset) begin
            compareSignal("memWrite", 12'd0, memWrite);
        end else if (retired < runLength) begin
            slot = cycleCount % 5;
            if (slot == 0) begin
                compareSignal("pc", modelPc, pc);
                stepModel();
            end
            compareSignal("memWrite", expectStore && (slot == 3), memWrite);
            if (expectStore && (slot == 3)) begin  // memory phase of SW
                compareSignal("dataAddress", expectAddress, dataAddress);
                compareSignal("dataOut", expectData, dataOut);
            end
            if (slot == 4) begin
                retired++;
            end
            cycleCount++;
        end
    end

    initial begin
        int propertyFailures;
        reset          = 1'b1;
        programWrite   = 1'b0;
        programAddress = '0;
        programData    = '0;
        modelPc        = '0;
        expectStore    = 1'b0;
        expectAddress  = '0;
        expectData     = '0;
        seed           = 32'ha8e;
        for (int i = 0; i < 4; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            modelMem[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            programImage[2 * i]          = $random(seed);
            programImage[2 * i][11:9]    = $unsigned($random(seed)) % 6;  // opcodes 0..5
            programImage[2 * i + 1]      = '0;
        end
        programImage[0][11:5] = {vsaPkg::opAddi, 2'd0, 2'd1};  // seed R1..R3
        programImage[2][11:5] = {vsaPkg::opAddi, 2'd0, 2'd2};
        programImage[4][11:5] = {vsaPkg::opAddi, 2'd0, 2'd3};
        programImage[6][11:9] = vsaPkg::opSw;
        // reload the stored word into R1 and store it again
        programImage[8]        = {vsaPkg::opLw, programImage[6][8:7], 2'd1,
                                  programImage[6][4:0]};
        programImage[10][11:5] = {vsaPkg::opSw, programImage[10][8:7], 2'd1};
        for (int i = 0; i < 32; i++) begin
            @(posedge clock);
            programWrite   <= 1'b1;
            programAddress <= i;
            programData    <= programImage[i];
        end
        @(posedge clock);
        programWrite <= 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        wait (retired == runLength);
        propertyFailures = vsaSystem_inst.core_inst.coreProperties_inst.failureCount;
        $display("checks %0d, errors %0d, property failures %0d",
                 checkCount, errorCount, propertyFailures);
        if (errorCount == 0 && propertyFailures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog counted from reset release
    initial begin
        @(negedge reset);
        #(watchdogCycles * clockPeriod);
        $display("timeout: the core did not finish %0d instructions in time", runLength);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== build.f ====
vsaPkg.sv
vsaControl.sv
vsaRegFile.sv
vsaAlu.sv
vsaMemory.sv
vsaCore.sv
vsaSystem.sv
vsaCoreProperties.sv
vsaSystemTb.sv
